/* Makefile */
TOP = tb_axi_fifo_bridge
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
+incdir+testbench
verilog/bridge_pkg.sv
verilog/sync_fifo.sv
verilog/axi_write_ctrl.sv
verilog/axi_read_ctrl.sv
verilog/axi_fifo_bridge.sv
testbench/tb_axi_fifo_bridge.sv

/* testbench/bridge_cases.txt */
// op addr beats first_word resp, all hex, resp 0 OKAY 2 SLVERR
// op 1 AXI write, 2 AXI read, 3 core push, 4 tx drain check, 0 end of list
1 00 4 A000 0
4 00 4 A000 0
2 10 1 0 0
3 00 3 B000 0
2 10 1 1 0
2 00 3 B000 0
1 24 2 C000 2
4 00 0 0 0
2 30 1 0 2
3 00 2 D000 0
2 00 4 0 2
2 00 2 D000 0
1 00 6 E000 0
3 00 5 F000 0
1 10 1 3 0
2 10 1 0 0
4 00 0 0 0
1 00 20 1234 0
4 00 20 1234 0
0 0 0 0 0

/* testbench/tb_bus_tasks.svh */
////////////////////////////////////////////////////////////
// Compare and count
////////////////////////////////////////////////////////////
task automatic check_value(input string what, input logic [127:0] got,
                           input logic [127:0] exp);
    if (got !== exp) begin
        $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        errors++;
    end
endtask

////////////////////////////////////////////////////////////
// AXI write burst, data is first word plus beat index
////////////////////////////////////////////////////////////
task automatic write_burst(input logic [5:0] addr, input logic [15:0] id, input int beats,
                           input logic [127:0] first, input logic [1:0] exp_resp);
    int           tx_fl0;
    int           rx_fl0;
    logic         done;
    logic [127:0] flush_bits;
    tx_fl0 = tx_flush_cnt;
    rx_fl0 = rx_flush_cnt;
    s_axi_aw.addr <= addr;
    s_axi_aw.id   <= id;
    s_axi_aw.len  <= 8'(beats - 1);
    s_axi_awvalid <= 1'b1;
    @(posedge s_axi_aclk);
    while (!s_axi_awready) @(posedge s_axi_aclk);
    s_axi_awvalid <= 1'b0;
    for (int i = 0; i < beats; i++) begin
        s_axi_wdata  <= first + i;
        s_axi_wvalid <= 1'b1;
        s_axi_wlast  <= (i == beats - 1);
        @(posedge s_axi_aclk);
        while (!s_axi_wready) @(posedge s_axi_aclk);   // Stalls while tx FIFO full
    end
    s_axi_wvalid <= 1'b0;
    s_axi_wlast  <= 1'b0;
    done = 1'b0;
    while (!done) begin
        s_axi_bready <= ($random(seed) & 3) != 0;   // Random B stall
        @(posedge s_axi_aclk);
        done = s_axi_bvalid && s_axi_bready;
    end
    s_axi_bready <= 1'b0;
    check_value("B resp", s_axi_b.resp, exp_resp);
    check_value("B id", s_axi_b.id, id);
    // Flush bits ride on the last beat
    flush_bits = (addr == 6'h10 && exp_resp == 2'b00) ? first + (beats - 1) : '0;
    check_value("tx flush pulses", tx_flush_cnt - tx_fl0, flush_bits[0]);
    check_value("rx flush pulses", rx_flush_cnt - rx_fl0, flush_bits[1]);
endtask

////////////////////////////////////////////////////////////
// AXI read, burst on 0x00, single beat otherwise
////////////////////////////////////////////////////////////
task automatic read_burst(input logic [5:0] addr, input logic [15:0] id, input int beats,
                          input logic [127:0] first, input logic [1:0] exp_resp);
    int n_exp;
    int beat;
    n_exp = (exp_resp == 2'b00 && addr == 6'h00) ? beats : 1;
    s_axi_ar.addr <= addr;
    s_axi_ar.id   <= id;
    s_axi_ar.len  <= 8'(beats - 1);
    s_axi_arvalid <= 1'b1;
    @(posedge s_axi_aclk);
    while (!s_axi_arready) @(posedge s_axi_aclk);
    s_axi_arvalid <= 1'b0;
    beat = 0;
    while (beat < n_exp) begin
        s_axi_rready <= ($random(seed) & 3) != 0;   // Random R stall
        @(posedge s_axi_aclk);
        if (s_axi_rvalid && s_axi_rready) begin
            check_value("R resp", s_axi_r.resp, exp_resp);
            check_value("R id", s_axi_r.id, id);
            check_value("R last", s_axi_r.last, beat == n_exp - 1);
            if (exp_resp == 2'b00) begin
                check_value("R data", s_axi_r.data, (addr == 6'h00) ? first + beat : first);
            end
            beat++;
        end
    end
    s_axi_rready <= 1'b0;
endtask

// Core strobes into rx FIFO, held while it is full
task automatic push_core_words(input int words, input logic [127:0] first);
    for (int i = 0; i < words; i++) begin
        core_rx_data  <= first + i;
        core_rx_valid <= 1'b1;
        @(posedge s_axi_aclk);
        while (!core_rx_ready) @(posedge s_axi_aclk);
    end
    core_rx_valid <= 1'b0;
endtask

// Release core_tx_full and collect the strobes
task automatic drain_tx(input int words, input logic [127:0] first);
    tx_seen.delete();
    core_tx_full <= 1'b0;
    @(posedge s_axi_aclk);
    while (tx_seen.size() < words) @(posedge s_axi_aclk);
    repeat (4) @(posedge s_axi_aclk);   // Quiet window, FIFO empty by now
    core_tx_full <= 1'b1;
    check_value("tx strobe count", tx_seen.size(), words);
    for (int i = 0; i < tx_seen.size() && i < words; i++) begin
        check_value("tx data", tx_seen[i], first + i);
    end
endtask

/* testbench/tb_axi_fifo_bridge.sv */
`timescale 1ns/1ps

module tb_axi_fifo_bridge;
    import bridge_pkg::*;

    localparam int cycles_per_case = 200;
    localparam int max_cases       = 50;

    logic                  s_axi_aclk = 1'b0;
    logic                  s_axi_aresetn;
    axi_addr_t             s_axi_aw;
    logic                  s_axi_awvalid;
    logic                  s_axi_awready;
    logic [data_width-1:0] s_axi_wdata;
    logic                  s_axi_wvalid;
    logic                  s_axi_wlast;
    logic                  s_axi_wready;
    axi_b_t                s_axi_b;
    logic                  s_axi_bvalid;
    logic                  s_axi_bready;
    axi_addr_t             s_axi_ar;
    logic                  s_axi_arvalid;
    logic                  s_axi_arready;
    axi_r_t                s_axi_r;
    logic                  s_axi_rvalid;
    logic                  s_axi_rready;
    logic [data_width-1:0] core_tx_data;
    logic                  core_tx_valid;
    logic                  core_tx_full;
    logic [data_width-1:0] core_rx_data;
    logic                  core_rx_valid;
    logic                  core_rx_ready;
    logic                  core_tx_flush;
    logic                  core_rx_flush;

    logic [127:0] cases_mem [0:5*max_cases-1];   // Five columns per case line
    logic [127:0] tx_seen [$];                   // Words seen on core_tx
    integer       seed = 2;
    int           errors = 0;
    int           tx_flush_cnt = 0;
    int           rx_flush_cnt = 0;
    int           cycles = 0;
    int           limit = 0;

    axi_fifo_bridge #(.data_width(data_width), .fifo_addr_width(fifo_addr_width)) uut (.*);

    always #4 s_axi_aclk = ~s_axi_aclk;   // 8 ns period

    `include "tb_bus_tasks.svh"

    ////////////////////////////////////////////////////////////
    // Monitors and watchdog
    ////////////////////////////////////////////////////////////
    always @(posedge s_axi_aclk) begin
        if (core_tx_valid) tx_seen.push_back(core_tx_data);
        if (core_tx_flush) tx_flush_cnt++;
        if (core_rx_flush) rx_flush_cnt++;
    end

    always @(posedge s_axi_aclk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Case runner
    ////////////////////////////////////////////////////////////
    initial begin
        int           n_cases;
        int           passed;
        int           failed;
        int           errs_before;
        int           beats;
        logic [3:0]   op;
        logic [5:0]   addr;
        logic [127:0] first;
        logic [1:0]   exp_resp;
        s_axi_aresetn = 1'b0;
        s_axi_aw      = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_wlast   = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_ar      = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        core_tx_full  = 1'b1;   // Hold tx words until a drain case
        core_rx_data  = '0;
        core_rx_valid = 1'b0;
        passed = 0;
        failed = 0;
        $readmemh("testbench/bridge_cases.txt", cases_mem);
        n_cases = 0;
        while (n_cases < max_cases && !$isunknown(cases_mem[5*n_cases])
               && cases_mem[5*n_cases] != 0) n_cases++;   // Op 0 ends the list
        limit = (n_cases + 1) * cycles_per_case;
        if (n_cases == 0) begin
            $display("The case file held no tests");
            errors++;
        end
        repeat (3) @(posedge s_axi_aclk);
        s_axi_aresetn <= 1'b1;
        @(posedge s_axi_aclk);
        @(posedge s_axi_aclk);
        check_value("awready after reset", s_axi_awready, 1'b1);
        check_value("arready after reset", s_axi_arready, 1'b1);
        check_value("bvalid after reset", s_axi_bvalid, 1'b0);
        check_value("rvalid after reset", s_axi_rvalid, 1'b0);
        check_value("flush after reset", {core_tx_flush, core_rx_flush}, 2'b00);
        $display("reset values: %s", (errors == 0) ? "ok" : "wrong");

        for (int c = 0; c < n_cases; c++) begin
            op          = cases_mem[5*c][3:0];
            addr        = cases_mem[5*c+1][5:0];
            beats       = cases_mem[5*c+2][8:0];
            first       = cases_mem[5*c+3];
            exp_resp    = cases_mem[5*c+4][1:0];
            errs_before = errors;
            case (op)
                4'd1: write_burst(addr, 16'h0100 + c[15:0], beats, first, exp_resp);
                4'd2: read_burst(addr, 16'h0200 + c[15:0], beats, first, exp_resp);
                4'd3: push_core_words(beats, first);
                4'd4: drain_tx(beats, first);
                default: begin
                    $display("Case %0d has an unknown operation %0d", c, op);
                    errors++;
                end
            endcase
            if (errors == errs_before) passed++;
            else failed++;
            $display("case %0d op %0d addr %02h beats %0d: %s", c, op, addr, beats,
                     (errors == errs_before) ? "ok" : "wrong");
        end

        $display("%0d cases run, %0d ok, %0d wrong, %0d check errors",
                 n_cases, passed, failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog/axi_fifo_bridge.sv */
`timescale 1ns/1ps

module axi_fifo_bridge #(
    parameter int data_width      = bridge_pkg::data_width,
    parameter int fifo_addr_width = bridge_pkg::fifo_addr_width
) (
    input  logic                  s_axi_aclk,
    input  logic                  s_axi_aresetn,
    // AW
    input  bridge_pkg::axi_addr_t s_axi_aw,
    input  logic                  s_axi_awvalid,
    output logic                  s_axi_awready,
    // W
    input  logic [data_width-1:0] s_axi_wdata,
    input  logic                  s_axi_wvalid,
    input  logic                  s_axi_wlast,
    output logic                  s_axi_wready,
    // B
    output bridge_pkg::axi_b_t    s_axi_b,
    output logic                  s_axi_bvalid,
    input  logic                  s_axi_bready,
    // AR
    input  bridge_pkg::axi_addr_t s_axi_ar,
    input  logic                  s_axi_arvalid,
    output logic                  s_axi_arready,
    // R
    output bridge_pkg::axi_r_t    s_axi_r,
    output logic                  s_axi_rvalid,
    input  logic                  s_axi_rready,
    // Core transmit
    output logic [data_width-1:0] core_tx_data,
    output logic                  core_tx_valid,
    input  logic                  core_tx_full,
    // Core receive
    input  logic [data_width-1:0] core_rx_data,
    input  logic                  core_rx_valid,
    output logic                  core_rx_ready,
    // Flush pulses
    output logic                  core_tx_flush,
    output logic                  core_rx_flush
);

    logic                     tx_push;
    logic [data_width-1:0]    tx_din;
    logic                     tx_full;
    logic                     tx_empty;
    logic                     tx_drain;
    logic                     clear_tx;
    logic                     clear_rx;
    logic                     rx_full;
    logic                     rx_pop;
    logic [data_width-1:0]    rx_head;
    logic [fifo_addr_width:0] rx_count;

    ////////////////////////////////////////////////////////////
    // Core side glue
    ////////////////////////////////////////////////////////////
    assign tx_drain      = !tx_empty && !core_tx_full;   // One word per cycle when allowed
    assign core_tx_valid = tx_drain;
    assign core_rx_ready = !rx_full;
    assign core_tx_flush = clear_tx;   // Same cycle as internal clear
    assign core_rx_flush = clear_rx;

    // Bus writes into transmit FIFO
    axi_write_ctrl #(.data_width(data_width)) u_write_ctrl (
        .s_axi_aclk, .s_axi_aresetn,
        .s_axi_aw, .s_axi_awvalid, .s_axi_awready,
        .s_axi_wdata, .s_axi_wvalid, .s_axi_wlast, .s_axi_wready,
        .s_axi_b, .s_axi_bvalid, .s_axi_bready,
        .tx_push, .tx_din, .tx_full, .clear_tx, .clear_rx
    );

    sync_fifo #(.data_width(data_width), .fifo_addr_width(fifo_addr_width)) tx_fifo (
        .s_axi_aclk, .s_axi_aresetn,
        .clear(clear_tx), .push(tx_push), .din(tx_din), .pop(tx_drain),
        .head(core_tx_data), .count(), .full(tx_full), .empty(tx_empty)
    );

    // Core words back out through bus reads
    sync_fifo #(.data_width(data_width), .fifo_addr_width(fifo_addr_width)) rx_fifo (
        .s_axi_aclk, .s_axi_aresetn,
        .clear(clear_rx), .push(core_rx_valid && core_rx_ready), .din(core_rx_data),
        .pop(rx_pop), .head(rx_head), .count(rx_count), .full(rx_full), .empty()
    );

    axi_read_ctrl #(.data_width(data_width), .fifo_addr_width(fifo_addr_width)) u_read_ctrl (
        .s_axi_aclk, .s_axi_aresetn,
        .s_axi_ar, .s_axi_arvalid, .s_axi_arready,
        .s_axi_r, .s_axi_rvalid, .s_axi_rready,
        .rx_head, .rx_count, .rx_pop
    );

endmodule

/* verilog/axi_read_ctrl.sv */
`timescale 1ns/1ps

module axi_read_ctrl #(
    parameter int data_width      = bridge_pkg::data_width,
    parameter int fifo_addr_width = bridge_pkg::fifo_addr_width
) (
    input  logic                     s_axi_aclk,
    input  logic                     s_axi_aresetn,
    // AR
    input  bridge_pkg::axi_addr_t    s_axi_ar,
    input  logic                     s_axi_arvalid,
    output logic                     s_axi_arready,
    // R
    output bridge_pkg::axi_r_t       s_axi_r,
    output logic                     s_axi_rvalid,
    input  logic                     s_axi_rready,
    // Receive FIFO
    input  logic [data_width-1:0]    rx_head,
    input  logic [fifo_addr_width:0] rx_count,
    output logic                     rx_pop
);
    import bridge_pkg::*;

    rd_state_t         state;
    logic [id_width-1:0] id_q;
    logic [7:0]        beats_left;   // Remaining beats minus one
    logic              status_q;     // Non-empty flag sampled at AR
    logic              ar_hs;
    logic              burst_fits;

    assign ar_hs = s_axi_arvalid && s_axi_arready;
    // Same as len+1 <= count without the carry
    assign burst_fits = (s_axi_ar.len < rx_count);

    ////////////////////////////////////////////////////////////
    // R channel
    ////////////////////////////////////////////////////////////
    assign s_axi_arready = (state == rd_idle);
    assign s_axi_rvalid  = (state != rd_idle);
    assign rx_pop        = (state == rd_data) && s_axi_rready;   // One word per accepted beat

    always_comb begin
        s_axi_r.id   = id_q;
        s_axi_r.resp = (state == rd_error) ? resp_slverr : resp_okay;
        s_axi_r.last = (state != rd_data) || (beats_left == 8'd0);  // Single-beat replies
        case (state)
            rd_data:   s_axi_r.data = rx_head;
            rd_status: s_axi_r.data = {{(data_width-1){1'b0}}, status_q};
            default:   s_axi_r.data = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state <= rd_idle;
        end else begin
            case (state)
                rd_idle: begin
                    if (ar_hs) begin
                        if (s_axi_ar.addr == addr_ctrl) begin
                            state <= rd_status;
                        end else if (s_axi_ar.addr == addr_fifo && burst_fits) begin
                            state <= rd_data;
                        end else begin
                            state <= rd_error;   // Bad address or underflow leaves FIFO untouched
                        end
                    end
                end
                rd_data: begin
                    if (s_axi_rready && beats_left == 8'd0) begin
                        state <= rd_idle;
                    end
                end
                rd_status, rd_error: begin
                    if (s_axi_rready) begin
                        state <= rd_idle;
                    end
                end
                default: state <= rd_idle;
            endcase
        end
    end

    // Request payload captured at AR
    always_ff @(posedge s_axi_aclk) begin
        if (ar_hs) begin
            id_q       <= s_axi_ar.id;
            beats_left <= s_axi_ar.len;
            status_q   <= (rx_count != '0);   // Frozen so R stays stable
        end else if (rx_pop) begin
            beats_left <= beats_left - 8'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Pops only on accepted data beats with enough words left
    ////////////////////////////////////////////////////////////
    a_pop_on_beat : assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        rx_pop |-> s_axi_rvalid && s_axi_rready && (state == rd_data) && (rx_count > beats_left)
    ) else $error("rx FIFO popped outside an accepted data beat");

endmodule

/* verilog/axi_write_ctrl.sv */
`timescale 1ns/1ps

module axi_write_ctrl #(
    parameter int data_width = bridge_pkg::data_width
) (
    input  logic                  s_axi_aclk,
    input  logic                  s_axi_aresetn,
    // AW
    input  bridge_pkg::axi_addr_t s_axi_aw,
    input  logic                  s_axi_awvalid,
    output logic                  s_axi_awready,
    // W
    input  logic [data_width-1:0] s_axi_wdata,
    input  logic                  s_axi_wvalid,
    input  logic                  s_axi_wlast,
    output logic                  s_axi_wready,
    // B
    output bridge_pkg::axi_b_t    s_axi_b,
    output logic                  s_axi_bvalid,
    input  logic                  s_axi_bready,
    // Transmit FIFO
    output logic                  tx_push,
    output logic [data_width-1:0] tx_din,
    input  logic                  tx_full,
    // Flush pulses to both FIFOs
    output logic                  clear_tx,
    output logic                  clear_rx
);
    import bridge_pkg::*;

    wr_state_t state;
    axi_b_t    b_q;          // Response held from AW until B handshake
    logic      aw_hs;
    logic      w_beat;
    logic      w_last_beat;
    logic      addr_hit;

    assign aw_hs       = s_axi_awvalid && s_axi_awready;
    assign w_beat      = s_axi_wvalid && s_axi_wready;
    assign w_last_beat = w_beat && s_axi_wlast;
    assign addr_hit    = (s_axi_aw.addr == addr_fifo) || (s_axi_aw.addr == addr_ctrl);

    ////////////////////////////////////////////////////////////
    // Handshake outputs
    ////////////////////////////////////////////////////////////
    assign s_axi_awready = (state == wr_idle);
    assign s_axi_wready  = (state == wr_data) ? !tx_full                        // FIFO back-pressure
                         : (state == wr_flush) || (state == wr_drop);           // Always sink
    assign s_axi_bvalid  = (state == wr_resp);   // Rises the cycle after wlast
    assign s_axi_b       = b_q;

    // Beats go straight in, visible in count next cycle
    assign tx_push = w_beat && (state == wr_data);
    assign tx_din  = s_axi_wdata;

    // Flush acts on the closing beat only
    assign clear_tx = w_last_beat && (state == wr_flush) && s_axi_wdata[0];
    assign clear_rx = w_last_beat && (state == wr_flush) && s_axi_wdata[1];

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state <= wr_idle;
        end else begin
            case (state)
                wr_idle: begin
                    if (aw_hs) begin
                        if (s_axi_aw.addr == addr_fifo) begin
                            state <= wr_data;
                        end else if (s_axi_aw.addr == addr_ctrl) begin
                            state <= wr_flush;
                        end else begin
                            state <= wr_drop;   // SLVERR after the burst drains
                        end
                    end
                end
                wr_data, wr_flush, wr_drop: begin
                    if (w_last_beat) begin
                        state <= wr_resp;
                    end
                end
                wr_resp: begin
                    if (s_axi_bready) begin
                        state <= wr_idle;
                    end
                end
                default: state <= wr_idle;
            endcase
        end
    end

    // ID and response decided at AW time
    always_ff @(posedge s_axi_aclk) begin
        if (aw_hs) begin
            b_q.id   <= s_axi_aw.id;
            b_q.resp <= addr_hit ? resp_okay : resp_slverr;
        end
    end

    ////////////////////////////////////////////////////////////
    // B channel must hold through a stall
    ////////////////////////////////////////////////////////////
    a_b_hold : assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_b)
    ) else $error("bvalid or B payload dropped before bready");

endmodule

/* verilog/bridge_pkg.sv */
package bridge_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////
    localparam int addr_width      = 6;    // Byte address, one word per beat
    localparam int data_width      = 128;  // Bus and core word
    localparam int id_width        = 16;
    localparam int fifo_addr_width = 5;    // 32 entries

    ////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////
    localparam logic [addr_width-1:0] addr_fifo = 6'h00;  // Data window, both directions
    localparam logic [addr_width-1:0] addr_ctrl = 6'h10;  // Flush on write, status on read

    // Bus response, AXI encoding
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } resp_t;

    // Write side FSM
    typedef enum logic [2:0] {
        wr_idle  = 3'd0,
        wr_data  = 3'd1,  // Beats into transmit FIFO
        wr_flush = 3'd2,  // Beats decoded as flush bits
        wr_drop  = 3'd3,  // Unmapped address, beats discarded
        wr_resp  = 3'd4
    } wr_state_t;

    // Read side FSM
    typedef enum logic [1:0] {
        rd_idle   = 2'd0,
        rd_data   = 2'd1,
        rd_status = 2'd2,
        rd_error  = 2'd3
    } rd_state_t;

    ////////////////////////////////////////////////////////////
    // Channel payloads
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [id_width-1:0]   id;
        logic [7:0]            len;   // Beats minus one
    } axi_addr_t;

    typedef struct packed {
        logic [id_width-1:0] id;
        resp_t               resp;
    } axi_b_t;

    typedef struct packed {
        logic [id_width-1:0]   id;
        logic [data_width-1:0] data;
        resp_t                 resp;
        logic                  last;
    } axi_r_t;

endpackage

/* verilog/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter int data_width      = bridge_pkg::data_width,
    parameter int fifo_addr_width = bridge_pkg::fifo_addr_width
) (
    input  logic                     s_axi_aclk,
    input  logic                     s_axi_aresetn,
    input  logic                     clear,
    input  logic                     push,
    input  logic [data_width-1:0]    din,
    input  logic                     pop,
    output logic [data_width-1:0]    head,
    output logic [fifo_addr_width:0] count,
    output logic                     full,
    output logic                     empty
);

    localparam int depth = 2 ** fifo_addr_width;

    logic [data_width-1:0]      mem [depth];
    logic [fifo_addr_width-1:0] wr_ptr;
    logic [fifo_addr_width-1:0] rd_ptr;

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (push && !clear) begin
            mem[wr_ptr] <= din;
        end
    end

    assign head  = mem[rd_ptr];   // Show-ahead, oldest word
    assign full  = (count == depth[fifo_addr_width:0]);
    assign empty = (count == '0);

    ////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn || clear) begin   // Clear wins over push and pop
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Producer and consumer must honour the flags
    ////////////////////////////////////////////////////////////
    a_no_overflow : assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        push && !clear |-> !full
    ) else $error("sync_fifo push while full");

    a_no_underflow : assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        pop && !clear |-> !empty
    ) else $error("sync_fifo pop while empty");

endmodule
